//--- sources.f
host_pkg.sv
llc_cfg_if.sv
llc_cfg_regs.sv
llc_perf_counters.sv
llc_region_decoder.sv
edge_propagator_rx.sv
host_domain.sv
tb_host_domain.sv

//--- tb_host_domain.sv
// Testbench for the host domain LLC control with bus driver, reference model and random stimulus
`timescale 1ns/1ps

module tb_host_domain import host_pkg::*; ();

  // Well above the cycles the whole sequence needs
  localparam int unsigned MaxCycles = 20000;

  logic        clk;
  logic        rst_n;
  logic        cfg_aw_valid;
  logic [31:0] cfg_aw_addr;
  logic        cfg_w_valid;
  logic [31:0] cfg_w_data;
  logic        cfg_b_ready;
  logic        cfg_ar_valid;
  logic [31:0] cfg_ar_addr;
  logic        cfg_r_ready;
  logic        cfg_aw_ready;
  logic        cfg_w_ready;
  logic        cfg_b_valid;
  lite_resp_e  cfg_b_resp;
  logic        cfg_ar_ready;
  logic        cfg_r_valid;
  logic [31:0] cfg_r_data;
  lite_resp_e  cfg_r_resp;
  logic        read_hit;
  logic        read_miss;
  logic        write_hit;
  logic        write_miss;
  logic        access_valid;
  logic [31:0] access_addr;
  logic        region_valid;
  llc_region_e region;
  logic        dma_valid;
  logic        dma_ack;
  logic        dma_evt;

  integer      seed = 32'ha813a4ea;
  int unsigned cycle_cnt = 0;

  // Reference model with counters indexed by register offset
  llc_window_t model_win;
  logic [31:0] model_cnt [3:7];

  host_domain i_dut (
    .clk_i              ( clk          ),
    .rst_n_i            ( rst_n        ),
    .cfg_aw_valid_i     ( cfg_aw_valid ),
    .cfg_aw_addr_i      ( cfg_aw_addr  ),
    .cfg_w_valid_i      ( cfg_w_valid  ),
    .cfg_w_data_i       ( cfg_w_data   ),
    .cfg_b_ready_i      ( cfg_b_ready  ),
    .cfg_ar_valid_i     ( cfg_ar_valid ),
    .cfg_ar_addr_i      ( cfg_ar_addr  ),
    .cfg_r_ready_i      ( cfg_r_ready  ),
    .cfg_aw_ready_o     ( cfg_aw_ready ),
    .cfg_w_ready_o      ( cfg_w_ready  ),
    .cfg_b_valid_o      ( cfg_b_valid  ),
    .cfg_b_resp_o       ( cfg_b_resp   ),
    .cfg_ar_ready_o     ( cfg_ar_ready ),
    .cfg_r_valid_o      ( cfg_r_valid  ),
    .cfg_r_data_o       ( cfg_r_data   ),
    .cfg_r_resp_o       ( cfg_r_resp   ),
    .llc_read_hit_i     ( read_hit     ),
    .llc_read_miss_i    ( read_miss    ),
    .llc_write_hit_i    ( write_hit    ),
    .llc_write_miss_i   ( write_miss   ),
    .access_valid_i     ( access_valid ),
    .access_addr_i      ( access_addr  ),
    .region_valid_o     ( region_valid ),
    .region_o           ( region       ),
    .dma_pe_evt_valid_i ( dma_valid    ),
    .dma_pe_evt_ack_o   ( dma_ack      ),
    .dma_pe_evt_o       ( dma_evt      )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Run did not finish within %0d clock cycles", MaxCycles);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input lite_resp_e exp_resp);
    int delay;
    @(posedge clk);
    cfg_aw_valid <= 1'b1;
    cfg_w_valid  <= 1'b1;
    cfg_aw_addr  <= addr;
    cfg_w_data   <= data;
    do @(negedge clk); while (!(cfg_aw_ready && cfg_w_ready));
    @(posedge clk);
    cfg_aw_valid <= 1'b0;
    cfg_w_valid  <= 1'b0;
    @(negedge clk);
    check_equal(cfg_b_valid, 1'b1, "write response one cycle after accept");
    check_equal(cfg_b_resp, exp_resp, $sformatf("write response at %h", addr));
    check_equal(cfg_aw_ready, 1'b0, "write address ready while response pending");
    check_equal(cfg_w_ready, 1'b0, "write data ready while response pending");
    delay = $random(seed) & 3;
    repeat (delay) begin
      @(negedge clk);
      check_equal(cfg_b_valid, 1'b1, "write response held under back-pressure");
    end
    @(posedge clk);
    cfg_b_ready <= 1'b1;
    @(posedge clk);
    cfg_b_ready <= 1'b0;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_data,
                            input lite_resp_e exp_resp);
    int delay;
    @(posedge clk);
    cfg_ar_valid <= 1'b1;
    cfg_ar_addr  <= addr;
    do @(negedge clk); while (!cfg_ar_ready);
    @(posedge clk);
    cfg_ar_valid <= 1'b0;
    @(negedge clk);
    check_equal(cfg_r_valid, 1'b1, "read response one cycle after accept");
    check_equal(cfg_r_data, exp_data, $sformatf("read data at %h", addr));
    check_equal(cfg_r_resp, exp_resp, $sformatf("read response at %h", addr));
    check_equal(cfg_ar_ready, 1'b0, "read address ready while response pending");
    delay = $random(seed) & 3;
    repeat (delay) begin
      @(negedge clk);
      check_equal(cfg_r_valid, 1'b1, "read response held under back-pressure");
      check_equal(cfg_r_data, exp_data, "read data held under back-pressure");
    end
    @(posedge clk);
    cfg_r_ready <= 1'b1;
    @(posedge clk);
    cfg_r_ready <= 1'b0;
  endtask

  function automatic logic [31:0] expected_reg(input int off);
    case (off)
      0:       return model_win.cache_start;
      1:       return model_win.cache_end;
      2:       return model_win.spm_start;
      3, 4, 5, 6, 7: return model_cnt[off];
      default: return LlcCfgDefaultData;
    endcase
  endfunction

  // Bus write plus the matching model update
  task automatic write_reg(input int off, input logic [31:0] data);
    lite_resp_e exp_resp;
    exp_resp = (off < 8) ? RESP_OKAY : RESP_SLVERR;
    bus_write(off << 2, data, exp_resp);
    case (off)
      0:       model_win.cache_start = data;
      1:       model_win.cache_end = data;
      2:       model_win.spm_start = data;
      3, 4, 5, 6, 7: model_cnt[off] = '0;
      default: ;
    endcase
  endtask

  function automatic llc_region_e classify(input logic [31:0] addr);
    if (model_win.spm_start != 0 && addr >= model_win.spm_start) begin
      return REGION_SPM;
    end
    if (addr >= model_win.cache_start && addr < model_win.cache_end) begin
      return REGION_CACHED;
    end
    return REGION_BYPASS;
  endfunction

  // Mostly addresses right at or next to a window edge
  function automatic logic [31:0] pick_addr();
    case ($random(seed) & 7)
      0:       return model_win.cache_start;
      1:       return model_win.cache_start - 1;
      2:       return model_win.cache_end;
      3:       return model_win.cache_end - 1;
      4:       return model_win.spm_start;
      5:       return model_win.spm_start - 1;
      default: return $random(seed);
    endcase
  endfunction

  initial begin
    int          i;
    int          w;
    int          off;
    int          pulses;
    int          gap;
    logic        v;
    logic        level;
    logic [31:0] addr;
    logic [31:0] cs;
    logic [3:0]  s;
    logic        exp_valid;
    llc_region_e exp_region;

    rst_n        = 1'b0;
    cfg_aw_valid = 1'b0;
    cfg_aw_addr  = '0;
    cfg_w_valid  = 1'b0;
    cfg_w_data   = '0;
    cfg_b_ready  = 1'b0;
    cfg_ar_valid = 1'b0;
    cfg_ar_addr  = '0;
    cfg_r_ready  = 1'b0;
    read_hit     = 1'b0;
    read_miss    = 1'b0;
    write_hit    = 1'b0;
    write_miss   = 1'b0;
    access_valid = 1'b0;
    access_addr  = '0;
    dma_valid    = 1'b0;
    model_win.cache_start = CacheStartReset;
    model_win.cache_end   = CacheEndReset;
    model_win.spm_start   = SpmStartReset;
    for (off = 3; off <= 7; off++) begin
      model_cnt[off] = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_equal(cfg_b_valid, 1'b0, "write response valid after reset");
    check_equal(cfg_r_valid, 1'b0, "read response valid after reset");
    check_equal(region_valid, 1'b0, "region valid after reset");
    check_equal(dma_ack, 1'b0, "DMA acknowledge after reset");
    check_equal(dma_evt, 1'b0, "DMA event pulse after reset");
    for (off = 0; off < 8; off++) begin
      read_check(off << 2, expected_reg(off), RESP_OKAY);
    end

    for (i = 0; i < 8; i++) begin
      off = ($random(seed) & 32'h7fff_ffff) % 3;
      write_reg(off, $random(seed));
      read_check(off << 2, expected_reg(off), RESP_OKAY);
    end

    for (i = 0; i < 6; i++) begin
      off = 8 + ($random(seed) & 7);
      read_check(off << 2, LlcCfgDefaultData, RESP_SLVERR);
      write_reg(off, $random(seed));
    end
    for (off = 0; off < 3; off++) begin
      read_check(off << 2, expected_reg(off), RESP_OKAY);
    end

    for (w = 0; w < 4; w++) begin
      cs = $random(seed);
      write_reg(0, cs);
      write_reg(1, cs + ($random(seed) & 32'h0fff_ffff));
      write_reg(2, ($random(seed) & 1) ? ($random(seed) | 32'hc000_0000) : 32'h0);
      exp_valid = 1'b0;
      for (i = 0; i <= 40; i++) begin
        @(posedge clk);
        v = (i < 40) && ($random(seed) & 1);
        addr = pick_addr();
        access_valid <= v;
        access_addr  <= addr;
        @(negedge clk);
        check_equal(region_valid, exp_valid, $sformatf("region valid, access %0d", i));
        if (exp_valid) begin
          check_equal(region, exp_region, $sformatf("region class, access %0d", i));
        end
        exp_valid  = v;
        exp_region = classify(addr);
      end
    end

    for (i = 0; i < 100; i++) begin
      @(posedge clk);
      s = $random(seed);
      read_hit   <= s[0];
      read_miss  <= s[1];
      write_hit  <= s[2];
      write_miss <= s[3];
      model_cnt[3] = model_cnt[3] + s[0];
      model_cnt[4] = model_cnt[4] + s[1];
      model_cnt[5] = model_cnt[5] + s[2];
      model_cnt[6] = model_cnt[6] + s[3];
    end
    @(posedge clk);
    read_hit   <= 1'b0;
    read_miss  <= 1'b0;
    write_hit  <= 1'b0;
    write_miss <= 1'b0;
    for (off = 3; off <= 6; off++) begin
      read_check(off << 2, expected_reg(off), RESP_OKAY);
    end
    for (off = 3; off <= 7; off++) begin
      write_reg(off, $random(seed));
      read_check(off << 2, expected_reg(off), RESP_OKAY);
    end

    level = 1'b0;
    for (i = 0; i < 8; i++) begin
      @(posedge clk);
      level = ~level;
      dma_valid <= level;
      model_cnt[7] = model_cnt[7] + 1;
      pulses = 0;
      gap = 6 + ($random(seed) & 3);
      repeat (gap) begin
        @(negedge clk);
        if (dma_evt) begin
          pulses++;
        end
      end
      check_equal(pulses, 1, $sformatf("DMA event pulses for toggle %0d", i));
      check_equal(dma_ack, level, $sformatf("DMA acknowledge for toggle %0d", i));
    end
    read_check(7 << 2, expected_reg(7), RESP_OKAY);
    write_reg(7, $random(seed));
    read_check(7 << 2, expected_reg(7), RESP_OKAY);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- host_domain.sv
// Host domain LLC control top with config slave, region decoder, counters and DMA event receiver
`timescale 1ns/1ps

module host_domain import host_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // LLC configuration bus
  input  logic                       cfg_aw_valid_i,
  input  logic [LiteAddrWidth-1:0]   cfg_aw_addr_i,
  input  logic                       cfg_w_valid_i,
  input  logic [LiteDataWidth-1:0]   cfg_w_data_i,
  input  logic                       cfg_b_ready_i,
  input  logic                       cfg_ar_valid_i,
  input  logic [LiteAddrWidth-1:0]   cfg_ar_addr_i,
  input  logic                       cfg_r_ready_i,
  output logic                       cfg_aw_ready_o,
  output logic                       cfg_w_ready_o,
  output logic                       cfg_b_valid_o,
  output lite_resp_e                 cfg_b_resp_o,
  output logic                       cfg_ar_ready_o,
  output logic                       cfg_r_valid_o,
  output logic [LiteDataWidth-1:0]   cfg_r_data_o,
  output lite_resp_e                 cfg_r_resp_o,
  // Cache event strobes
  input  logic                       llc_read_hit_i,
  input  logic                       llc_read_miss_i,
  input  logic                       llc_write_hit_i,
  input  logic                       llc_write_miss_i,
  // Memory accesses to classify
  input  logic                       access_valid_i,
  input  logic [AccessAddrWidth-1:0] access_addr_i,
  output logic                       region_valid_o,
  output llc_region_e                region_o,
  // Cluster DMA event
  input  logic                       dma_pe_evt_valid_i,
  output logic                       dma_pe_evt_ack_o,
  output logic                       dma_pe_evt_o
);

  llc_window_t                              window;
  logic [NumCounters-1:0][CounterWidth-1:0] counters;
  logic [NumCounters-1:0]                   counter_clr;
  logic                                     dma_evt;

  llc_cfg_if cfg_bus ();

  assign cfg_bus.aw_valid = cfg_aw_valid_i;
  assign cfg_bus.aw_addr  = cfg_aw_addr_i;
  assign cfg_bus.w_valid  = cfg_w_valid_i;
  assign cfg_bus.w_data   = cfg_w_data_i;
  assign cfg_bus.b_ready  = cfg_b_ready_i;
  assign cfg_bus.ar_valid = cfg_ar_valid_i;
  assign cfg_bus.ar_addr  = cfg_ar_addr_i;
  assign cfg_bus.r_ready  = cfg_r_ready_i;

  assign cfg_aw_ready_o = cfg_bus.aw_ready;
  assign cfg_w_ready_o  = cfg_bus.w_ready;
  assign cfg_b_valid_o  = cfg_bus.b_valid;
  assign cfg_b_resp_o   = cfg_bus.b_resp;
  assign cfg_ar_ready_o = cfg_bus.ar_ready;
  assign cfg_r_valid_o  = cfg_bus.r_valid;
  assign cfg_r_data_o   = cfg_bus.r_data;
  assign cfg_r_resp_o   = cfg_bus.r_resp;

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .cfg           ( cfg_bus     ),
    .counters_i    ( counters    ),
    .counter_clr_o ( counter_clr ),
    .window_o      ( window      )
  );

  llc_perf_counters i_llc_perf_counters (
    .clk_i        ( clk_i            ),
    .rst_n_i      ( rst_n_i          ),
    .read_hit_i   ( llc_read_hit_i   ),
    .read_miss_i  ( llc_read_miss_i  ),
    .write_hit_i  ( llc_write_hit_i  ),
    .write_miss_i ( llc_write_miss_i ),
    .dma_evt_i    ( dma_evt          ),
    .clr_i        ( counter_clr      ),
    .counters_o   ( counters         )
  );

  llc_region_decoder i_llc_region_decoder (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .window_i       ( window         ),
    .access_valid_i ( access_valid_i ),
    .access_addr_i  ( access_addr_i  ),
    .region_valid_o ( region_valid_o ),
    .region_o       ( region_o       )
  );

  edge_propagator_rx ep_dma_pe_evt_i (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .valid_o ( dma_evt            )
  );

  assign dma_pe_evt_o = dma_evt;

endmodule

//--- edge_propagator_rx.sv
// Receiver for a toggle event crossing into this clock, with acknowledge and pulse output
`timescale 1ns/1ps

module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic valid_o
);

  logic [1:0] sync_q;
  logic       prev_q;
  logic       pulse_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q  <= '0;
      prev_q  <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      prev_q  <= sync_q[1];
      // One pulse per level change
      pulse_q <= sync_q[1] ^ prev_q;
    end
  end

  // Sender sees its toggle level returned once synchronized
  assign ack_o   = sync_q[1];
  assign valid_o = pulse_q;

endmodule

//--- llc_region_decoder.sv
// Registered classifier of memory accesses into cached, scratchpad or bypass regions
`timescale 1ns/1ps

module llc_region_decoder import host_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  llc_window_t                window_i,
  input  logic                       access_valid_i,
  input  logic [AccessAddrWidth-1:0] access_addr_i,
  output logic                       region_valid_o,
  output llc_region_e                region_o
);

  llc_region_e region_d;
  llc_region_e region_q;
  logic        valid_q;

  // Scratchpad window wins, start of zero disables it
  always_comb begin
    if (window_i.spm_start != '0 && access_addr_i >= window_i.spm_start) begin
      region_d = REGION_SPM;
    end else if (access_addr_i >= window_i.cache_start &&
                 access_addr_i < window_i.cache_end) begin
      region_d = REGION_CACHED;
    end else begin
      region_d = REGION_BYPASS;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= access_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_valid_i) begin
      region_q <= region_d;
    end
  end

  assign region_valid_o = valid_q;
  assign region_o       = region_q;

endmodule

//--- llc_perf_counters.sv
// LLC event counters for cache hit and miss strobes and DMA events
`timescale 1ns/1ps

module llc_perf_counters import host_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     read_hit_i,
  input  logic                                     read_miss_i,
  input  logic                                     write_hit_i,
  input  logic                                     write_miss_i,
  input  logic                                     dma_evt_i,
  input  logic [NumCounters-1:0]                   clr_i,
  output logic [NumCounters-1:0][CounterWidth-1:0] counters_o
);

  logic [NumCounters-1:0]                   strobe;
  logic [NumCounters-1:0][CounterWidth-1:0] cnt_q;

  assign strobe[CntRdHit]  = read_hit_i;
  assign strobe[CntRdMiss] = read_miss_i;
  assign strobe[CntWrHit]  = write_hit_i;
  assign strobe[CntWrMiss] = write_miss_i;
  assign strobe[CntDmaEvt] = dma_evt_i;

  for (genvar i = 0; i < NumCounters; i++) begin : g_cnt
    // Clear has priority, counters wrap
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (clr_i[i]) begin
        cnt_q[i] <= '0;
      end else if (strobe[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign counters_o = cnt_q;

endmodule

//--- llc_cfg_regs.sv
// LLC configuration slave holding the address windows and reading back event counters
`timescale 1ns/1ps

module llc_cfg_regs import host_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  llc_cfg_if.slave                                 cfg,
  input  logic [NumCounters-1:0][CounterWidth-1:0] counters_i,
  output logic [NumCounters-1:0]                   counter_clr_o,
  output llc_window_t                              window_o
);

  logic                     b_valid_q;
  lite_resp_e               b_resp_q;
  logic                     r_valid_q;
  logic [LiteDataWidth-1:0] r_data_q;
  lite_resp_e               r_resp_q;
  llc_window_t              window_q;
  llc_window_t              window_d;
  logic                     wr_en;
  logic                     rd_en;
  llc_reg_e                 wr_off;
  llc_reg_e                 rd_off;
  lite_resp_e               wr_resp;
  logic [LiteDataWidth-1:0] rd_data;
  lite_resp_e               rd_resp;

  // One outstanding response per channel
  assign cfg.aw_ready = ~b_valid_q;
  assign cfg.w_ready  = ~b_valid_q;
  assign cfg.ar_ready = ~r_valid_q;
  assign cfg.b_valid  = b_valid_q;
  assign cfg.b_resp   = b_resp_q;
  assign cfg.r_valid  = r_valid_q;
  assign cfg.r_data   = r_data_q;
  assign cfg.r_resp   = r_resp_q;

  assign wr_en  = cfg.aw_valid & cfg.w_valid & ~b_valid_q;
  assign rd_en  = cfg.ar_valid & ~r_valid_q;
  assign wr_off = llc_reg_e'(cfg.aw_addr[5:2]);
  assign rd_off = llc_reg_e'(cfg.ar_addr[5:2]);

  // Write decode, counter offsets only clear
  always_comb begin
    window_d      = window_q;
    counter_clr_o = '0;
    wr_resp       = RESP_OKAY;
    if (wr_en) begin
      case (wr_off)
        REG_CACHE_START: window_d.cache_start = cfg.w_data;
        REG_CACHE_END:   window_d.cache_end   = cfg.w_data;
        REG_SPM_START:   window_d.spm_start   = cfg.w_data;
        REG_RD_HIT_CNT:  counter_clr_o[CntRdHit]  = 1'b1;
        REG_RD_MISS_CNT: counter_clr_o[CntRdMiss] = 1'b1;
        REG_WR_HIT_CNT:  counter_clr_o[CntWrHit]  = 1'b1;
        REG_WR_MISS_CNT: counter_clr_o[CntWrMiss] = 1'b1;
        REG_DMA_EVT_CNT: counter_clr_o[CntDmaEvt] = 1'b1;
        default:         wr_resp = RESP_SLVERR;
      endcase
    end
  end

  always_comb begin
    rd_data = LlcCfgDefaultData;
    rd_resp = RESP_OKAY;
    case (rd_off)
      REG_CACHE_START: rd_data = window_q.cache_start;
      REG_CACHE_END:   rd_data = window_q.cache_end;
      REG_SPM_START:   rd_data = window_q.spm_start;
      REG_RD_HIT_CNT:  rd_data = counters_i[CntRdHit];
      REG_RD_MISS_CNT: rd_data = counters_i[CntRdMiss];
      REG_WR_HIT_CNT:  rd_data = counters_i[CntWrHit];
      REG_WR_MISS_CNT: rd_data = counters_i[CntWrMiss];
      REG_DMA_EVT_CNT: rd_data = counters_i[CntDmaEvt];
      default:         rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q            <= 1'b0;
      r_valid_q            <= 1'b0;
      window_q.cache_start <= CacheStartReset;
      window_q.cache_end   <= CacheEndReset;
      window_q.spm_start   <= SpmStartReset;
    end else begin
      window_q <= window_d;
      if (wr_en) begin
        b_valid_q <= 1'b1;
      end else if (cfg.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
      end else if (cfg.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payload, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      b_resp_q <= wr_resp;
    end
    if (rd_en) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  assign window_o = window_q;

endmodule

//--- llc_cfg_if.sv
// LLC configuration lite bus bundle between the top level and the register block
`timescale 1ns/1ps

interface llc_cfg_if import host_pkg::*; ();

  logic                     aw_valid;
  logic                     aw_ready;
  logic [LiteAddrWidth-1:0] aw_addr;
  logic                     w_valid;
  logic                     w_ready;
  logic [LiteDataWidth-1:0] w_data;
  logic                     b_valid;
  logic                     b_ready;
  lite_resp_e               b_resp;
  logic                     ar_valid;
  logic                     ar_ready;
  logic [LiteAddrWidth-1:0] ar_addr;
  logic                     r_valid;
  logic                     r_ready;
  logic [LiteDataWidth-1:0] r_data;
  lite_resp_e               r_resp;

  modport master (
    output aw_valid, aw_addr, w_valid, w_data, b_ready, ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

  modport slave (
    input  aw_valid, aw_addr, w_valid, w_data, b_ready, ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

endinterface

//--- host_pkg.sv
// Host domain LLC control package with widths, reset values, register map and shared types
package host_pkg;

  localparam int unsigned LiteAddrWidth   = 32;
  localparam int unsigned LiteDataWidth   = 32;
  localparam int unsigned AccessAddrWidth = 32;
  localparam int unsigned CounterWidth    = 32;
  localparam int unsigned NumCounters     = 5;

  // Returned for reads outside the register map
  localparam logic [LiteDataWidth-1:0] LlcCfgDefaultData = 32'hdeadf000;

  localparam logic [AccessAddrWidth-1:0] CacheStartReset = 32'h8000_0000;
  localparam logic [AccessAddrWidth-1:0] CacheEndReset   = 32'h9000_0000;
  localparam logic [AccessAddrWidth-1:0] SpmStartReset   = 32'h0000_0000;

  // Counter slots in the counter array
  localparam int unsigned CntRdHit  = 0;
  localparam int unsigned CntRdMiss = 1;
  localparam int unsigned CntWrHit  = 2;
  localparam int unsigned CntWrMiss = 3;
  localparam int unsigned CntDmaEvt = 4;

  // Word offsets, address bits 5:2
  typedef enum logic [3:0] {
    REG_CACHE_START = 4'd0,
    REG_CACHE_END   = 4'd1,
    REG_SPM_START   = 4'd2,
    REG_RD_HIT_CNT  = 4'd3,
    REG_RD_MISS_CNT = 4'd4,
    REG_WR_HIT_CNT  = 4'd5,
    REG_WR_MISS_CNT = 4'd6,
    REG_DMA_EVT_CNT = 4'd7
  } llc_reg_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } lite_resp_e;

  typedef enum logic [1:0] {
    REGION_BYPASS = 2'd0,
    REGION_CACHED = 2'd1,
    REGION_SPM    = 2'd2
  } llc_region_e;

  typedef struct packed {
    logic [AccessAddrWidth-1:0] cache_start;
    logic [AccessAddrWidth-1:0] cache_end;
    logic [AccessAddrWidth-1:0] spm_start;
  } llc_window_t;

endpackage
